// ==== design/pcie_link_cfg.svh ====
`ifndef PCIE_LINK_CFG_SVH
`define PCIE_LINK_CFG_SVH

// ------------------------------------------------------------------------
// Stream field widths
// ------------------------------------------------------------------------
`define PCIE_DATA_W      64   // Payload data per beat
`define PCIE_TAG_W       10   // Wide enough for 10-bit tag mode
`define PCIE_REQID_W     16   // Bus/device/function
`define PCIE_ADDR_W      32

// ------------------------------------------------------------------------
// Queue depths
// ------------------------------------------------------------------------
`define COMMIT_DEPTH     4    // Outstanding write commits
`define RXREQ_DEPTH      2    // RXREQ skid ahead of the arbiter

// ------------------------------------------------------------------------
// Control shadow
// ------------------------------------------------------------------------
`define SHADOW_W         40
`define SHADOW_TAG8_BIT  8    // Extended 8-bit tag enable
`define SHADOW_TAG10_BIT 9    // 10-bit tag requester enable

`endif

// ==== design/pcie_link_pkg.sv ====
`include "pcie_link_cfg.svh"

package pcie_link_pkg;

   // ---------------------------------------------------------------------
   // Packet header
   // ---------------------------------------------------------------------
   typedef enum logic [1:0]
   {
      MEM_RD = 2'd0,
      MEM_WR = 2'd1,
      CPL    = 2'd2,   // Completion without data
      CPL_D  = 2'd3
   } t_pcie_op;

   typedef struct packed
   {
      t_pcie_op                 op;
      logic [`PCIE_TAG_W-1:0]   tag;
      logic [`PCIE_REQID_W-1:0] req_id;
      logic [`PCIE_ADDR_W-1:0]  addr;
   } t_pcie_hdr;

   // One beat per packet, so no tlast
   typedef struct packed
   {
      t_pcie_hdr               hdr;
      logic [`PCIE_DATA_W-1:0] data;
   } t_axis_beat;

   // Enough of a write to build its completion
   typedef struct packed
   {
      logic [`PCIE_TAG_W-1:0]   tag;
      logic [`PCIE_REQID_W-1:0] req_id;
   } t_commit_info;

   // Exactly one flag set
   typedef struct packed
   {
      logic tag_5bit;
      logic tag_8bit;
      logic tag_10bit;
   } t_tag_mode;

endpackage : pcie_link_pkg

// ==== design/pcie_stream_fifo.sv ====
`timescale 1ns/1ps

module pcie_stream_fifo #(
   parameter type T_PAYLOAD = logic [7:0],
   parameter int  DEPTH     = 4
)(
   input  logic     fim_clk,
   input  logic     arst_n,
   input  T_PAYLOAD in,
   input  logic     in_valid,
   output logic     in_ready,
   output T_PAYLOAD out,
   output logic     out_valid,
   input  logic     out_ready
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   T_PAYLOAD         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             push;
   logic             pop;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(DEPTH - 1))
         return '0;
      return ptr + 1'b1;
   endfunction

   assign in_ready  = (count != CNT_W'(DEPTH));
   assign out_valid = (count != '0);
   assign out       = mem[rd_ptr];
   assign push      = in_valid && in_ready;
   assign pop       = out_valid && out_ready;

   always_ff @(posedge fim_clk)
   begin
      if (push)
         mem[wr_ptr] <= in;
   end

   always_ff @(posedge fim_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push) wr_ptr <= next_ptr(wr_ptr);
         if (pop)  rd_ptr <= next_ptr(rd_ptr);
         count <= count + CNT_W'(push) - CNT_W'(pop);   // Both at once leaves it unchanged
      end
   end

   a_count_bound : assert property (@(posedge fim_clk) disable iff (!arst_n)
      count <= CNT_W'(DEPTH));

   // A push offered while full and not draining must not move the write side
   a_full_no_push : assert property (@(posedge fim_clk) disable iff (!arst_n)
      (!in_ready && in_valid && !out_ready) |=> (!in_ready && $stable(wr_ptr)));

endmodule : pcie_stream_fifo

// ==== design/pcie_write_commit.sv ====
`timescale 1ns/1ps
`include "pcie_link_cfg.svh"

module pcie_write_commit (
   input  logic                        fim_clk,
   input  logic                        arst_n,

   // Accelerator TX
   input  pcie_link_pkg::t_axis_beat   afu_tx,
   input  logic                        afu_tx_valid,
   output logic                        afu_tx_ready,

   // Toward the subsystem
   output pcie_link_pkg::t_axis_beat   ss_tx,
   output logic                        ss_tx_valid,
   input  logic                        ss_tx_ready,

   // Commit records toward the arbiter
   output pcie_link_pkg::t_commit_info commit,
   output logic                        commit_valid,
   input  logic                        commit_ready
);

   pcie_link_pkg::t_commit_info commit_rec;
   logic                        slot_free;   // Commit queue has room
   logic                        is_wr;
   logic                        rec_push;

   // ---------------------------------------------------------------------
   // TX pass-through
   // ---------------------------------------------------------------------
   // Every beat waits for a free slot, so a write never reaches the
   // subsystem without a place for its record
   assign is_wr        = (afu_tx.hdr.op == pcie_link_pkg::MEM_WR);
   assign ss_tx        = afu_tx;
   assign ss_tx_valid  = afu_tx_valid && slot_free;
   assign afu_tx_ready = ss_tx_ready && slot_free;

   // ---------------------------------------------------------------------
   // Commit queue
   // ---------------------------------------------------------------------
   assign rec_push          = afu_tx_valid && afu_tx_ready && is_wr;
   assign commit_rec.tag    = afu_tx.hdr.tag;
   assign commit_rec.req_id = afu_tx.hdr.req_id;

   pcie_stream_fifo #(
      .T_PAYLOAD ( pcie_link_pkg::t_commit_info ),
      .DEPTH     ( `COMMIT_DEPTH )
   ) commit_fifo (
      .fim_clk   ( fim_clk      ),
      .arst_n    ( arst_n       ),
      .in        ( commit_rec   ),
      .in_valid  ( rec_push     ),
      .in_ready  ( slot_free    ),
      .out       ( commit       ),
      .out_valid ( commit_valid ),
      .out_ready ( commit_ready )
   );

   // A write is only offered while the queue holds fewer than its depth
   a_no_wr_when_full : assert property (@(posedge fim_clk) disable iff (!arst_n)
      (ss_tx_valid && is_wr) |-> (commit_fifo.count < `COMMIT_DEPTH));

   // Each write taken by the subsystem has its record visible next cycle
   a_wr_has_record : assert property (@(posedge fim_clk) disable iff (!arst_n)
      (ss_tx_valid && ss_tx_ready && is_wr) |=> commit_valid);

endmodule : pcie_write_commit

// ==== design/pcie_rxreq_arbiter.sv ====
`timescale 1ns/1ps
`include "pcie_link_cfg.svh"

module pcie_rxreq_arbiter (
   input  logic                        fim_clk,
   input  logic                        arst_n,

   input  pcie_link_pkg::t_axis_beat   ss_rxreq,
   input  logic                        ss_rxreq_valid,
   output logic                        ss_rxreq_ready,

   input  pcie_link_pkg::t_commit_info commit,
   input  logic                        commit_valid,
   output logic                        commit_ready,

   output pcie_link_pkg::t_axis_beat   afu_rxreq,
   output logic                        afu_rxreq_valid,
   input  logic                        afu_rxreq_ready
);

   pcie_link_pkg::t_axis_beat rxq_beat;
   pcie_link_pkg::t_axis_beat cpl_beat;
   logic                      rxq_valid;
   logic                      rxq_ready;
   logic                      load_en;
   logic                      grant_commit;
   logic                      last_commit;   // Commit channel won last time

   pcie_stream_fifo #(
      .T_PAYLOAD ( pcie_link_pkg::t_axis_beat ),
      .DEPTH     ( `RXREQ_DEPTH )
   ) rxreq_fifo (
      .fim_clk   ( fim_clk        ),
      .arst_n    ( arst_n         ),
      .in        ( ss_rxreq       ),
      .in_valid  ( ss_rxreq_valid ),
      .in_ready  ( ss_rxreq_ready ),
      .out       ( rxq_beat       ),
      .out_valid ( rxq_valid      ),
      .out_ready ( rxq_ready      )
   );

   // Completion without data for a committed write
   assign cpl_beat.hdr.op     = pcie_link_pkg::CPL;
   assign cpl_beat.hdr.tag    = commit.tag;
   assign cpl_beat.hdr.req_id = commit.req_id;
   assign cpl_beat.hdr.addr   = '0;
   assign cpl_beat.data       = '0;

   // ---------------------------------------------------------------------
   // Round-robin grant and output register
   // ---------------------------------------------------------------------
   assign load_en      = !afu_rxreq_valid || afu_rxreq_ready;   // Empty or draining
   assign grant_commit = commit_valid && (!rxq_valid || !last_commit);
   assign rxq_ready    = load_en && !grant_commit;
   assign commit_ready = load_en && grant_commit;

   always_ff @(posedge fim_clk)
   begin
      if (load_en)
         afu_rxreq <= grant_commit ? cpl_beat : rxq_beat;
   end

   always_ff @(posedge fim_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         afu_rxreq_valid <= 1'b0;
         last_commit     <= 1'b0;
      end
      else if (load_en)
      begin
         afu_rxreq_valid <= rxq_valid || commit_valid;
         if (rxq_valid || commit_valid)
            last_commit <= grant_commit;
      end
   end

   a_out_stable : assert property (@(posedge fim_clk) disable iff (!arst_n)
      (afu_rxreq_valid && !afu_rxreq_ready) |=> (afu_rxreq_valid && $stable(afu_rxreq)));

endmodule : pcie_rxreq_arbiter

// ==== design/pcie_tag_mode.sv ====
`timescale 1ns/1ps
`include "pcie_link_cfg.svh"

module pcie_tag_mode (
   input  logic                     fim_clk,
   input  logic                     arst_n,
   input  logic                     ctrlshadow_valid,
   input  logic [`SHADOW_W-1:0]     ctrlshadow_data,
   output pcie_link_pkg::t_tag_mode tag_mode
);

   pcie_link_pkg::t_tag_mode mode_dec;

   // 10-bit enable wins over extended 8-bit
   always_comb
   begin
      mode_dec = '0;
      if (ctrlshadow_data[`SHADOW_TAG10_BIT])
         mode_dec.tag_10bit = 1'b1;
      else if (ctrlshadow_data[`SHADOW_TAG8_BIT])
         mode_dec.tag_8bit = 1'b1;
      else
         mode_dec.tag_5bit = 1'b1;
   end

   always_ff @(posedge fim_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         tag_mode           <= '0;
         tag_mode.tag_5bit  <= 1'b1;   // Legacy mode until the host says otherwise
      end
      else if (ctrlshadow_valid)
      begin
         tag_mode <= mode_dec;
      end
   end

   a_mode_onehot : assert property (@(posedge fim_clk) disable iff (!arst_n)
      $onehot(tag_mode));

endmodule : pcie_tag_mode

// ==== design/pcie_link_path.sv ====
`timescale 1ns/1ps
`include "pcie_link_cfg.svh"

module pcie_link_path (
   input  logic                      fim_clk,
   input  logic                      arst_n,

   input  pcie_link_pkg::t_axis_beat afu_tx,
   input  logic                      afu_tx_valid,
   output logic                      afu_tx_ready,

   output pcie_link_pkg::t_axis_beat ss_tx,
   output logic                      ss_tx_valid,
   input  logic                      ss_tx_ready,

   input  pcie_link_pkg::t_axis_beat ss_rxreq,
   input  logic                      ss_rxreq_valid,
   output logic                      ss_rxreq_ready,

   output pcie_link_pkg::t_axis_beat afu_rxreq,
   output logic                      afu_rxreq_valid,
   input  logic                      afu_rxreq_ready,

   input  logic                      ctrlshadow_valid,
   input  logic [`SHADOW_W-1:0]      ctrlshadow_data,
   output pcie_link_pkg::t_tag_mode  tag_mode
);

   // Commit stream between the two stages
   pcie_link_pkg::t_commit_info commit;
   logic                        commit_valid;
   logic                        commit_ready;

   pcie_write_commit local_commit (
      .fim_clk, .arst_n,
      .afu_tx, .afu_tx_valid, .afu_tx_ready,
      .ss_tx, .ss_tx_valid, .ss_tx_ready,
      .commit, .commit_valid, .commit_ready
   );

   pcie_rxreq_arbiter rxreq_mux (
      .fim_clk, .arst_n,
      .ss_rxreq, .ss_rxreq_valid, .ss_rxreq_ready,
      .commit, .commit_valid, .commit_ready,
      .afu_rxreq, .afu_rxreq_valid, .afu_rxreq_ready
   );

   pcie_tag_mode tag_mode_dec (
      .fim_clk          ( fim_clk          ),
      .arst_n           ( arst_n           ),
      .ctrlshadow_valid ( ctrlshadow_valid ),
      .ctrlshadow_data  ( ctrlshadow_data  ),
      .tag_mode         ( tag_mode         )
   );

endmodule : pcie_link_path

// ==== test/tb_pcie_link_vectors.svh ====
`ifndef TB_PCIE_LINK_VECTORS_SVH
`define TB_PCIE_LINK_VECTORS_SVH

// Packet scenario columns are the TX beat count, the TX ops (2 bits per beat, beat 0 lowest),
// the RXREQ beat count and the ready pattern (0 always, 1 random, 2 afu_rxreq_ready low early)
typedef struct packed
{
   logic [3:0]  n_tx;
   logic [15:0] tx_ops;
   logic [3:0]  n_rxreq;
   logic [1:0]  ready_mode;
} t_pkt_case;

localparam int N_SHADOW = 5;
localparam int N_PKT    = 5;

// Shadow columns are the control-shadow word and the expected {tag_5bit, tag_8bit, tag_10bit}
logic [`SHADOW_W+2:0] shadow_cases [N_SHADOW];
t_pkt_case            pkt_cases    [N_PKT];

task automatic load_vectors();
   shadow_cases[0] = {40'h00_0000_0000, 3'b100};
   shadow_cases[1] = {40'h00_0000_0100, 3'b010};
   shadow_cases[2] = {40'h00_0000_0300, 3'b001};   // Both enables set so 10-bit wins
   shadow_cases[3] = {40'hFF_FFFF_FCFF, 3'b100};   // Every bit but the two enables
   shadow_cases[4] = {40'h00_0000_0200, 3'b001};
   pkt_cases[0]    = {4'd4, 16'h00D1, 4'd3, 2'd0};
   pkt_cases[1]    = {4'd8, 16'h9999, 4'd6, 2'd1};
   pkt_cases[2]    = {4'd8, 16'h5555, 4'd2, 2'd2};   // Writes only so commits back up
   pkt_cases[3]    = {4'd0, 16'h0000, 4'd5, 2'd1};
   pkt_cases[4]    = {4'd7, 16'h1E4D, 4'd0, 2'd1};
endtask

`endif

// ==== test/tb_pcie_link_path.sv ====
`timescale 1ns/1ps
`include "pcie_link_cfg.svh"

module tb_pcie_link_path;

   `include "tb_pcie_link_vectors.svh"

   logic                      fim_clk = 1'b0;
   logic                      arst_n, afu_tx_valid, afu_tx_ready, ss_tx_valid, ss_tx_ready;
   logic                      ss_rxreq_valid, ss_rxreq_ready, afu_rxreq_valid, afu_rxreq_ready;
   logic                      ctrlshadow_valid;
   logic [`SHADOW_W-1:0]      ctrlshadow_data;
   pcie_link_pkg::t_axis_beat afu_tx, ss_tx, ss_rxreq, afu_rxreq, beat;
   pcie_link_pkg::t_tag_mode  tag_mode;
   pcie_link_pkg::t_axis_beat tx_beats[$], rxq_beats[$], exp_tx[$], exp_cpl[$], exp_rxq[$];
   integer                    seed = 23;
   int                        err_cnt, check_cnt, test_cnt, tx_idx, rxq_idx, stall_cnt;
   bit                        vectors_loaded;

   pcie_link_path dut (.*);

   always #50 fim_clk = ~fim_clk;

   task automatic expect_equal(input logic [127:0] got, input logic [127:0] exp,
                               input string what);
      check_cnt++;
      if (got !== exp)
      begin
         err_cnt++;
         $display("** Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      end
   endtask

   function automatic pcie_link_pkg::t_axis_beat make_beat(input pcie_link_pkg::t_pcie_op op);
      pcie_link_pkg::t_axis_beat b;
      logic [31:0]               rnd;
      rnd          = $random(seed);
      b.hdr.op     = op;
      b.hdr.tag    = rnd[`PCIE_TAG_W-1:0];
      b.hdr.req_id = rnd[31:16];
      b.hdr.addr   = $random(seed);
      b.data       = {$random(seed), $random(seed)};
      return b;
   endfunction

   // ------------------------------------------------------------------------
   // Monitor of the handshakes at the rising edge
   // ------------------------------------------------------------------------
   always @(posedge fim_clk)
   begin
      if (arst_n)
      begin
         if (afu_tx_valid && afu_tx_ready) tx_idx++;
         if (ss_rxreq_valid && ss_rxreq_ready) rxq_idx++;
         expect_equal(ss_tx_valid && ss_tx_ready, afu_tx_valid && afu_tx_ready, "TX handshake");
         if (afu_tx_valid && ss_tx_ready && !afu_tx_ready
             && afu_tx.hdr.op == pcie_link_pkg::MEM_WR)
         begin
            stall_cnt++;
            expect_equal(ss_tx_valid, 0, "write offered to ss_tx while stalled");
         end
         if (ss_tx_valid && ss_tx_ready)
         begin
            expect_equal(exp_tx.size() != 0, 1, "ss_tx beat with none pending");
            if (exp_tx.size() != 0)
            begin
               beat = exp_tx.pop_front();
               expect_equal(ss_tx, beat, "ss_tx beat");
               if (beat.hdr.op == pcie_link_pkg::MEM_WR)
               begin
                  // Commit queue plus the output register bound the writes in flight
                  expect_equal(exp_cpl.size() <= `COMMIT_DEPTH, 1, "writes in flight");
                  beat.hdr.op   = pcie_link_pkg::CPL;
                  beat.hdr.addr = '0;
                  beat.data     = '0;
                  exp_cpl.push_back(beat);
               end
            end
         end
         if (afu_rxreq_valid && afu_rxreq_ready)
         begin
            if (afu_rxreq.hdr.op == pcie_link_pkg::CPL)
            begin
               expect_equal(exp_cpl.size() != 0, 1, "completion with no write pending");
               if (exp_cpl.size() != 0)
                  expect_equal(afu_rxreq, exp_cpl.pop_front(), "commit completion");
            end
            else
            begin
               expect_equal(exp_rxq.size() != 0, 1, "afu_rxreq beat with none pending");
               if (exp_rxq.size() != 0)
                  expect_equal(afu_rxreq, exp_rxq.pop_front(), "afu_rxreq beat");
            end
         end
      end
   end

   // ------------------------------------------------------------------------
   // Stimulus driven on the falling edge
   // ------------------------------------------------------------------------
   initial
   begin
      t_pkt_case                pc;
      pcie_link_pkg::t_pcie_op  op;
      int                       n_wr;
      int                       cyc;
      int                       errs_before;
      {afu_tx, afu_tx_valid, ss_tx_ready, ss_rxreq, ss_rxreq_valid} = '0;
      {afu_rxreq_ready, ctrlshadow_valid, ctrlshadow_data} = '0;
      arst_n = 1'b0;
      load_vectors();
      vectors_loaded = 1'b1;
      repeat (5) @(negedge fim_clk);
      arst_n = 1'b1;
      @(negedge fim_clk);
      expect_equal(tag_mode, 3'b100, "tag_mode after reset");
      expect_equal({afu_rxreq_valid, ss_tx_valid}, 2'b00, "valids after reset");
      expect_equal(ss_rxreq_ready, 1, "ss_rxreq_ready after reset");   // Empty RXREQ queue
      test_cnt++;
      $display("Test %0d reset done, %0d errors", test_cnt, err_cnt);

      for (int i = 0; i < N_SHADOW; i++)
      begin
         errs_before      = err_cnt;
         ctrlshadow_valid = 1'b1;
         ctrlshadow_data  = shadow_cases[i][`SHADOW_W+2:3];
         @(negedge fim_clk);
         ctrlshadow_valid = 1'b0;
         ctrlshadow_data  = ~shadow_cases[i][`SHADOW_W+2:3];   // Ignored without a strobe
         expect_equal(tag_mode, shadow_cases[i][2:0], "tag_mode after strobe");
         repeat (2) @(negedge fim_clk);
         expect_equal(tag_mode, shadow_cases[i][2:0], "tag_mode held");
         test_cnt++;
         $display("Test %0d tag mode vector %0d done, %0d errors", test_cnt, i,
                  err_cnt - errs_before);
      end

      for (int t = 0; t < N_PKT; t++)
      begin
         pc          = pkt_cases[t];
         errs_before = err_cnt;
         n_wr        = 0;
         tx_beats.delete();
         rxq_beats.delete();
         for (int i = 0; i < pc.n_tx; i++)
         begin
            tx_beats.push_back(make_beat(pcie_link_pkg::t_pcie_op'(pc.tx_ops[2*i +: 2])));
            n_wr += (tx_beats[i].hdr.op == pcie_link_pkg::MEM_WR);
         end
         for (int i = 0; i < pc.n_rxreq; i++)
         begin
            op = ($random(seed) & 1) ? pcie_link_pkg::MEM_WR : pcie_link_pkg::MEM_RD;
            rxq_beats.push_back(make_beat(op));   // Requests only and never CPL
         end
         exp_tx    = tx_beats;
         exp_rxq   = rxq_beats;
         tx_idx    = 0;
         rxq_idx   = 0;
         stall_cnt = 0;
         cyc       = 0;
         while (tx_idx < pc.n_tx || rxq_idx < pc.n_rxreq || exp_tx.size() != 0
                || exp_cpl.size() != 0 || exp_rxq.size() != 0)
         begin
            afu_tx_valid   = (tx_idx < pc.n_tx);
            ss_rxreq_valid = (rxq_idx < pc.n_rxreq);
            if (afu_tx_valid) afu_tx = tx_beats[tx_idx];
            if (ss_rxreq_valid) ss_rxreq = rxq_beats[rxq_idx];
            ss_tx_ready     = (pc.ready_mode == 2'd1) ? (($random(seed) & 1) != 0) : 1'b1;
            afu_rxreq_ready = (pc.ready_mode == 2'd1) ? (($random(seed) & 1) != 0)
                            : (pc.ready_mode == 2'd2) ? (cyc >= 24) : 1'b1;
            @(negedge fim_clk);
            cyc++;
         end
         afu_tx_valid    = 1'b0;
         ss_rxreq_valid  = 1'b0;
         afu_rxreq_ready = 1'b1;
         repeat (3) @(negedge fim_clk);
         expect_equal(afu_rxreq_valid, 0, "afu_rxreq idle after the last beat");
         if (pc.ready_mode == 2'd2 && n_wr > `COMMIT_DEPTH + 1)
            expect_equal(stall_cnt != 0, 1, "afu_tx never stalled on full commit queue");
         test_cnt++;
         $display("Test %0d packet case %0d done in %0d cycles, %0d errors", test_cnt, t,
                  cyc, err_cnt - errs_before);
      end

      $display("Tests: %0d, checks: %0d, errors: %0d", test_cnt, check_cnt, err_cnt);
      if (err_cnt == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

   // Limit is 20 cycles per beat in the table plus margin for reset and tag tests
   initial
   begin
      int limit;
      wait (vectors_loaded);
      limit = 300;
      for (int i = 0; i < N_PKT; i++)
         limit += 20 * (2 * pkt_cases[i].n_tx + pkt_cases[i].n_rxreq);
      repeat (limit) @(posedge fim_clk);
      $display("Watchdog: the run was still busy after %0d cycles and was stopped", limit);
      $display("Result: FAILED");
      $finish;
   end

endmodule : tb_pcie_link_path

// ==== flist.f ====
+incdir+design
+incdir+test
design/pcie_link_pkg.sv
design/pcie_stream_fifo.sv
design/pcie_write_commit.sv
design/pcie_rxreq_arbiter.sv
design/pcie_tag_mode.sv
design/pcie_link_path.sv
test/tb_pcie_link_path.sv
